// File: tcmBank.f
+incdir+include
logic/tcmPkg.sv
logic/tcSram.sv
logic/tcmBankArbiter.sv
logic/tcmRespRouter.sv
logic/tcmTop.sv
tb/tcmChecker.sv
tb/tcmTb.sv

// File: Makefile
# Verilator build and run of the banked TCM testbench.
# The simulator binary is rebuilt only when a source or the file list changes.

SRCS := $(wildcard include/*.svh logic/*.sv tb/*.sv) tcmBank.f
BIN  := obj_dir/VtcmTb

.PHONY: all run clean

all: run

$(BIN): $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tcmTb -f tcmBank.f

# the run passes only if the log holds the pass line
run: $(BIN)
	./$(BIN) | tee sim.log
	@grep -qx "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb/tcmTb.sv
// ----------------------------------------------------------------------
// tcmTb
// drives the banked memory from a stimulus table, then random traffic
// checking is done by tcmChecker, which watches the DUT ports
// ----------------------------------------------------------------------

`timescale 1ns/1ns

`include "tcm_defines.svh"

module tcmTb;

  import tcmPkg::*;

  localparam int RandCycles = 200;
  localparam int NameW      = 128;

  // one table row is one cycle of both requesters
  typedef struct packed {
    logic [NameW-1:0]        name;
    logic [`TCM_NUM_REQ-1:0] req;
    logic [`TCM_NUM_REQ-1:0] we;
    addrT [`TCM_NUM_REQ-1:0] addr;
    dataT [`TCM_NUM_REQ-1:0] wdata;
    beT   [`TCM_NUM_REQ-1:0] be;
  } stimRowT;

  logic                    clk;
  logic                    rstN;
  logic [NameW-1:0]        testName;
  logic [`TCM_NUM_REQ-1:0] req;
  logic [`TCM_NUM_REQ-1:0] we;
  addrT [`TCM_NUM_REQ-1:0] addr;
  dataT [`TCM_NUM_REQ-1:0] wdata;
  beT   [`TCM_NUM_REQ-1:0] be;
  logic [`TCM_NUM_REQ-1:0] gnt;
  logic [`TCM_NUM_REQ-1:0] rvalid;
  dataT [`TCM_NUM_REQ-1:0] rdata;
  // grants of the cycle that just ended
  logic [`TCM_NUM_REQ-1:0] lastGnt;
  stimRowT                 stimQ [$];
  int                      checkCnt;
  int                      mismatchCnt;
  int                      otherCnt;
  int                      cycleCnt;
  int                      timeoutLimit;

  tcmTop DUT (
    .clk_i   (clk),
    .rst_ni  (rstN),
    .req_i   (req),
    .we_i    (we),
    .addr_i  (addr),
    .wdata_i (wdata),
    .be_i    (be),
    .gnt_o   (gnt),
    .rvalid_o(rvalid),
    .rdata_o (rdata)
  );

  tcmChecker portChecker (
    .clk_i        (clk),
    .rst_ni       (rstN),
    .testName_i   (testName),
    .req_i        (req),
    .we_i         (we),
    .addr_i       (addr),
    .wdata_i      (wdata),
    .be_i         (be),
    .gnt_i        (gnt),
    .rvalid_i     (rvalid),
    .rdata_i      (rdata),
    .checkCnt_o   (checkCnt),
    .mismatchCnt_o(mismatchCnt),
    .otherCnt_o   (otherCnt)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  always @(posedge clk) begin
    lastGnt <= gnt;
  end

  // bit 0 of req and we belongs to requester 0
  task automatic addRow(input logic [NameW-1:0] name, input logic [1:0] rq,
                        input logic [1:0] wr, input addrT a0, input addrT a1,
                        input dataT d0, input dataT d1, input beT b0, input beT b1);
    stimRowT row;
    row.name     = name;
    row.req      = rq;
    row.we       = wr;
    row.addr[0]  = a0;
    row.addr[1]  = a1;
    row.wdata[0] = d0;
    row.wdata[1] = d1;
    row.be[0]    = b0;
    row.be[1]    = b1;
    stimQ.push_back(row);
  endtask

  task automatic driveRow(input stimRowT row);
    testName = row.name;
    req      = row.req;
    we       = row.we;
    addr     = row.addr;
    wdata    = row.wdata;
    be       = row.be;
  endtask

  task automatic fillTable();
    addRow("reset_idle", 2'b00, 2'b00, 10'h000, 10'h000, 32'h0, 32'h0, 4'h0, 4'h0);
    addRow("reset_idle", 2'b00, 2'b00, 10'h000, 10'h000, 32'h0, 32'h0, 4'h0, 4'h0);
    // banks 1 and 2, never written yet
    addRow("first_read", 2'b11, 2'b00, 10'h005, 10'h3fe, 32'h0, 32'h0, 4'h0, 4'h0);
    addRow("write_full", 2'b01, 2'b01, 10'h010, 10'h000, 32'h11223344, 32'h0, 4'hf, 4'h0);
    // lanes 0 and 2 only
    addRow("partial_write", 2'b01, 2'b01, 10'h010, 10'h000, 32'haabbccdd, 32'h0, 4'h5, 4'h0);
    addRow("read_merge", 2'b01, 2'b00, 10'h010, 10'h000, 32'h0, 32'h0, 4'h0, 4'h0);
    addRow("diff_banks", 2'b11, 2'b11, 10'h021, 10'h022, 32'hcafef00d, 32'h0badbeef,
           4'hf, 4'hf);
    addRow("diff_banks", 2'b11, 2'b00, 10'h022, 10'h021, 32'h0, 32'h0, 4'h0, 4'h0);
    // bank 3 contested, losers hold their request
    addRow("contend", 2'b11, 2'b11, 10'h003, 10'h007, 32'h1, 32'h2, 4'hf, 4'hf);
    addRow("contend", 2'b11, 2'b10, 10'h003, 10'h007, 32'h0, 32'h2, 4'h0, 4'hf);
    addRow("contend", 2'b11, 2'b00, 10'h003, 10'h007, 32'h0, 32'h0, 4'h0, 4'h0);
    addRow("contend", 2'b10, 2'b00, 10'h000, 10'h007, 32'h0, 32'h0, 4'h0, 4'h0);
    // write wins bank 0, the read of the same word follows
    addRow("same_word", 2'b11, 2'b01, 10'h010, 10'h010, 32'h55667788, 32'h0, 4'hf, 4'h0);
    addRow("same_word", 2'b10, 2'b00, 10'h000, 10'h010, 32'h0, 32'h0, 4'h0, 4'h0);
    addRow("back_to_back", 2'b11, 2'b00, 10'h021, 10'h3fe, 32'h0, 32'h0, 4'h0, 4'h0);
    addRow("back_to_back", 2'b11, 2'b00, 10'h005, 10'h022, 32'h0, 32'h0, 4'h0, 4'h0);
    addRow("idle", 2'b00, 2'b00, 10'h000, 10'h000, 32'h0, 32'h0, 4'h0, 4'h0);
  endtask

  initial begin
    void'($urandom(18188));
    rstN     = 1'b0;
    testName = "reset";
    req      = '0;
    we       = '0;
    addr     = '0;
    wdata    = '0;
    be       = '0;
    fillTable();
    timeoutLimit = stimQ.size() + RandCycles + 20;
    repeat (2) @(negedge clk);
    rstN = 1'b1;
    foreach (stimQ[i]) begin
      @(negedge clk);
      driveRow(stimQ[i]);
    end
    for (int c = 0; c < RandCycles; c++) begin
      @(negedge clk);
      testName = "random";
      for (int r = 0; r < `TCM_NUM_REQ; r++) begin
        // an ungranted request stays as it was
        if (!(req[r] && !lastGnt[r])) begin
          req[r]   = 1'(($urandom % 4) != 0);
          we[r]    = 1'($urandom % 2);
          addr[r]  = addrT'($urandom % 32);
          wdata[r] = $urandom;
          be[r]    = beT'($urandom_range(15, 1));
        end
      end
    end
    @(negedge clk);
    testName = "drain";
    req      = '0;
    repeat (3) @(negedge clk);
    $display("checks %0d, mismatches %0d, other errors %0d", checkCnt, mismatchCnt, otherCnt);
    if (mismatchCnt == 0 && otherCnt == 0 && checkCnt > 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // stops a run that outlives the table, the random phase and a margin
  initial begin
    cycleCnt = 0;
    @(posedge rstN);
    while (cycleCnt <= timeoutLimit) begin
      @(posedge clk);
      cycleCnt++;
    end
    $display("timeout: run still going after %0d cycles", cycleCnt);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

// File: tb/tcmChecker.sv
// ----------------------------------------------------------------------
// tcmChecker
// reference model of the banked memory and its round-robin arbiters
// compares grants every cycle and read responses one cycle later
// ----------------------------------------------------------------------

`timescale 1ns/1ns

`include "tcm_defines.svh"

module tcmChecker (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic         [127:0]                testName_i,
  input  logic         [`TCM_NUM_REQ-1:0]     req_i,
  input  logic         [`TCM_NUM_REQ-1:0]     we_i,
  input  tcmPkg::addrT [`TCM_NUM_REQ-1:0]     addr_i,
  input  tcmPkg::dataT [`TCM_NUM_REQ-1:0]     wdata_i,
  input  tcmPkg::beT   [`TCM_NUM_REQ-1:0]     be_i,
  input  logic         [`TCM_NUM_REQ-1:0]     gnt_i,
  input  logic         [`TCM_NUM_REQ-1:0]     rvalid_i,
  input  tcmPkg::dataT [`TCM_NUM_REQ-1:0]     rdata_i,
  output int                                  checkCnt_o,
  output int                                  mismatchCnt_o,
  output int                                  otherCnt_o
);

  import tcmPkg::*;

  localparam int Words = `TCM_NUM_BANKS * `TCM_ROWS_PER_BANK;
  localparam int BankW = $bits(bankIdxT);
  localparam int ByteW = `TCM_BYTE_WIDTH;

  // whole memory indexed by word address
  dataT         memModel [Words];
  // priority pointer per bank
  reqIdxT       ptrModel [`TCM_NUM_BANKS];
  // reads granted last cycle, with their expected data
  logic [`TCM_NUM_REQ-1:0] pendRd;
  dataT         pendData [`TCM_NUM_REQ];
  logic [127:0] pendName [`TCM_NUM_REQ];

  // lanes with be set take the new byte
  function automatic dataT mergeBytes(input dataT oldW, input dataT newW, input beT be);
    dataT res;
    res = oldW;
    for (int b = 0; b < $bits(beT); b++) begin
      if (be[b]) begin
        res[b*ByteW +: ByteW] = newW[b*ByteW +: ByteW];
      end
    end
    return res;
  endfunction

  always @(posedge clk_i or negedge rst_ni) begin
    logic [`TCM_NUM_REQ-1:0] expGnt;
    logic [`TCM_NUM_REQ-1:0] tgt;
    if (!rst_ni) begin
      for (int w = 0; w < Words; w++) begin
        memModel[w] = '0;
      end
      for (int b = 0; b < `TCM_NUM_BANKS; b++) begin
        ptrModel[b] = '0;
      end
      pendRd        = '0;
      checkCnt_o    = 0;
      mismatchCnt_o = 0;
      otherCnt_o    = 0;
    end else begin
      // responses due from last cycle's reads
      for (int r = 0; r < `TCM_NUM_REQ; r++) begin
        if (rvalid_i[r] !== 1'b1 && pendRd[r]) begin
          otherCnt_o++;
          $display("error: requester %0d got no response to its read in test %0s",
                   r, pendName[r]);
        end else if (rvalid_i[r] === 1'b1 && !pendRd[r]) begin
          otherCnt_o++;
          $display("error: requester %0d raised rvalid with no read outstanding in test %0s",
                   r, testName_i);
        end else if (pendRd[r]) begin
          checkCnt_o++;
          if (rdata_i[r] !== pendData[r]) begin
            mismatchCnt_o++;
            $display("mismatch test %0s rdata[%0d] expected %h actual %h",
                     pendName[r], r, pendData[r], rdata_i[r]);
          end
        end
      end
      // grants per bank, contested ones go to the pointer
      expGnt = '0;
      for (int b = 0; b < `TCM_NUM_BANKS; b++) begin
        for (int r = 0; r < `TCM_NUM_REQ; r++) begin
          tgt[r] = req_i[r] && (addr_i[r][BankW-1:0] == bankIdxT'(b));
        end
        if (&tgt) begin
          expGnt[ptrModel[b]] = 1'b1;
          ptrModel[b]         = ~ptrModel[b];
        end else begin
          expGnt = expGnt | tgt;
        end
      end
      checkCnt_o++;
      if (gnt_i !== expGnt) begin
        mismatchCnt_o++;
        $display("mismatch test %0s gnt expected %b actual %b", testName_i, expGnt, gnt_i);
      end
      // reads see the memory as it was before this edge's writes
      for (int r = 0; r < `TCM_NUM_REQ; r++) begin
        pendRd[r]   = expGnt[r] && !we_i[r];
        pendData[r] = memModel[addr_i[r]];
        pendName[r] = testName_i;
      end
      for (int r = 0; r < `TCM_NUM_REQ; r++) begin
        if (expGnt[r] && we_i[r]) begin
          memModel[addr_i[r]] = mergeBytes(memModel[addr_i[r]], wdata_i[r], be_i[r]);
        end
      end
    end
  end

endmodule

// File: logic/tcmTop.sv
// ----------------------------------------------------------------------
// tcmTop
// banked data memory shared by two requesters
// one arbiter and one SRAM per bank, one response router
// ----------------------------------------------------------------------

`timescale 1ns/1ns

`include "tcm_defines.svh"

module tcmTop (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic         [`TCM_NUM_REQ-1:0]     req_i,
  input  logic         [`TCM_NUM_REQ-1:0]     we_i,
  input  tcmPkg::addrT [`TCM_NUM_REQ-1:0]     addr_i,
  input  tcmPkg::dataT [`TCM_NUM_REQ-1:0]     wdata_i,
  input  tcmPkg::beT   [`TCM_NUM_REQ-1:0]     be_i,
  output logic         [`TCM_NUM_REQ-1:0]     gnt_o,
  output logic         [`TCM_NUM_REQ-1:0]     rvalid_o,
  output tcmPkg::dataT [`TCM_NUM_REQ-1:0]     rdata_o
);

  import tcmPkg::*;

  // per-bank SRAM strobes
  logic [`TCM_NUM_BANKS-1:0]                    sramReq;
  logic [`TCM_NUM_BANKS-1:0]                    sramWe;
  rowT  [`TCM_NUM_BANKS-1:0]                    sramRow;
  dataT [`TCM_NUM_BANKS-1:0]                    sramWdata;
  beT   [`TCM_NUM_BANKS-1:0]                    sramBe;
  dataT [`TCM_NUM_BANKS-1:0]                    bankRdata;
  // grants of each bank towards each requester
  logic [`TCM_NUM_BANKS-1:0][`TCM_NUM_REQ-1:0]  bankGnt;

  for (genvar b = 0; b < `TCM_NUM_BANKS; b++) begin : genBank
    // every arbiter sees all requests and filters its own bank
    tcmBankArbiter #(
      .BankIdx(b)
    ) bankArb (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .req_i      (req_i),
      .we_i       (we_i),
      .addr_i     (addr_i),
      .wdata_i    (wdata_i),
      .be_i       (be_i),
      .sramReq_o  (sramReq[b]),
      .sramWe_o   (sramWe[b]),
      .sramRow_o  (sramRow[b]),
      .sramWdata_o(sramWdata[b]),
      .sramBe_o   (sramBe[b]),
      .bankGnt_o  (bankGnt[b])
    );

    tcSram #(
      .NumWords(`TCM_ROWS_PER_BANK),
      .Latency (`TCM_READ_LATENCY)
    ) bankSram (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .req_i  (sramReq[b]),
      .we_i   (sramWe[b]),
      .addr_i (sramRow[b]),
      .wdata_i(sramWdata[b]),
      .be_i   (sramBe[b]),
      .rdata_o(bankRdata[b])
    );
  end

  // latency must match the SRAM chain
  tcmRespRouter #(
    .Latency(`TCM_READ_LATENCY)
  ) respRouter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .bankGnt_i  (bankGnt),
    .we_i       (we_i),
    .bankRdata_i(bankRdata),
    .gnt_o      (gnt_o),
    .rvalid_o   (rvalid_o),
    .rdata_o    (rdata_o)
  );

endmodule

// File: logic/tcmRespRouter.sv
// ----------------------------------------------------------------------
// tcmRespRouter
// collects the bank grants into one grant per requester
// tracks granted reads and returns bank data after the read latency
// ----------------------------------------------------------------------

`timescale 1ns/1ns

`include "tcm_defines.svh"

module tcmRespRouter #(
  parameter int unsigned Latency = `TCM_READ_LATENCY
) (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic [`TCM_NUM_BANKS-1:0][`TCM_NUM_REQ-1:0]   bankGnt_i,
  input  logic [`TCM_NUM_REQ-1:0]                       we_i,
  input  tcmPkg::dataT [`TCM_NUM_BANKS-1:0]             bankRdata_i,
  output logic [`TCM_NUM_REQ-1:0]                       gnt_o,
  output logic [`TCM_NUM_REQ-1:0]                       rvalid_o,
  output tcmPkg::dataT [`TCM_NUM_REQ-1:0]               rdata_o
);

  import tcmPkg::*;

  // grants regrouped per requester
  logic    [`TCM_NUM_REQ-1:0][`TCM_NUM_BANKS-1:0] gntByReq;
  // granted reads this cycle and the bank serving each
  logic    [`TCM_NUM_REQ-1:0]                     rdGnt;
  bankIdxT [`TCM_NUM_REQ-1:0]                     rdBank;
  // bank whose data is due at the output
  bankIdxT [`TCM_NUM_REQ-1:0]                     outBank;

  always_comb begin
    for (int r = 0; r < `TCM_NUM_REQ; r++) begin
      rdBank[r] = '0;
      for (int b = 0; b < `TCM_NUM_BANKS; b++) begin
        gntByReq[r][b] = bankGnt_i[b][r];
        if (bankGnt_i[b][r]) begin
          rdBank[r] = bankIdxT'(b);
        end
      end
    end
  end

  for (genvar r = 0; r < `TCM_NUM_REQ; r++) begin : genReq
    assign gnt_o[r]   = |gntByReq[r];
    // writes never produce a response
    assign rdGnt[r]   = gnt_o[r] && !we_i[r];
    assign rdata_o[r] = bankRdata_i[outBank[r]];

    // at most one bank may answer a requester
    assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(gntByReq[r]))
      else $error("requester %0d granted by banks %b", r, gntByReq[r]);
  end

  if (Latency == 0) begin : genNoLat
    assign rvalid_o = rdGnt;
    assign outBank  = rdBank;
  end else begin : genLat
    // one record per requester per stage, stage 0 is the oldest
    logic    [`TCM_NUM_REQ-1:0] vldQ  [Latency];
    bankIdxT [`TCM_NUM_REQ-1:0] bankQ [Latency];

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        for (int unsigned s = 0; s < Latency; s++) begin
          vldQ[s] <= '0;
        end
      end else begin
        vldQ[Latency-1] <= rdGnt;
        for (int unsigned s = 0; s + 1 < Latency; s++) begin
          vldQ[s] <= vldQ[s+1];
        end
      end
    end

    always_ff @(posedge clk_i) begin
      bankQ[Latency-1] <= rdBank;
      for (int unsigned s = 0; s + 1 < Latency; s++) begin
        bankQ[s] <= bankQ[s+1];
      end
    end

    assign rvalid_o = vldQ[0];
    assign outBank  = bankQ[0];
  end

endmodule

// File: logic/tcmBankArbiter.sv
// ----------------------------------------------------------------------
// tcmBankArbiter
// decodes which requests hit this bank and picks one winner
// contested cycles are resolved by a round-robin pointer
// the winner's strobes are muxed onto the bank SRAM
// ----------------------------------------------------------------------

`timescale 1ns/1ns

`include "tcm_defines.svh"

module tcmBankArbiter #(
  parameter int unsigned BankIdx = 0
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic         [`TCM_NUM_REQ-1:0]      req_i,
  input  logic         [`TCM_NUM_REQ-1:0]      we_i,
  input  tcmPkg::addrT [`TCM_NUM_REQ-1:0]      addr_i,
  input  tcmPkg::dataT [`TCM_NUM_REQ-1:0]      wdata_i,
  input  tcmPkg::beT   [`TCM_NUM_REQ-1:0]      be_i,
  output logic                                 sramReq_o,
  output logic                                 sramWe_o,
  output tcmPkg::rowT                          sramRow_o,
  output tcmPkg::dataT                         sramWdata_o,
  output tcmPkg::beT                           sramBe_o,
  output logic         [`TCM_NUM_REQ-1:0]      bankGnt_o
);

  import tcmPkg::*;

  localparam int unsigned BankW  = $bits(bankIdxT);
  localparam int unsigned AddrW  = $bits(addrT);
  localparam bankIdxT     MyBank = bankIdxT'(BankIdx);

  // requests aimed at this bank
  logic [`TCM_NUM_REQ-1:0] target;
  logic                    contested;
  // round-robin pointer, first requester looked at
  reqIdxT                  ptrQ;
  reqIdxT                  nextPtr;
  reqIdxT                  winIdx;
  logic                    winValid;

  // bank field sits in the low word-address bits
  for (genvar r = 0; r < `TCM_NUM_REQ; r++) begin : genTarget
    assign target[r] = req_i[r] && (addr_i[r][BankW-1:0] == MyBank);
  end

  assign contested = ($countones(target) > 1);

  // search from the pointer, first hit wins
  always_comb begin
    int idx;
    winIdx   = ptrQ;
    winValid = 1'b0;
    for (int k = 0; k < `TCM_NUM_REQ; k++) begin
      idx = (int'(ptrQ) + k) % `TCM_NUM_REQ;
      if (!winValid && target[idx]) begin
        winIdx   = reqIdxT'(idx);
        winValid = 1'b1;
      end
    end
  end

  // a target wins if it holds the pointer or the pointer's requester is idle here
  for (genvar r = 0; r < `TCM_NUM_REQ; r++) begin : genGnt
    assign bankGnt_o[r] = target[r] && ((ptrQ == reqIdxT'(r)) || !target[ptrQ]);
  end

  // winner's strobes to the SRAM, row is the upper address part
  assign sramReq_o   = winValid;
  assign sramWe_o    = winValid && we_i[winIdx];
  assign sramRow_o   = addr_i[winIdx][AddrW-1:BankW];
  assign sramWdata_o = wdata_i[winIdx];
  assign sramBe_o    = be_i[winIdx];

  // after a contested grant the next requester gets priority
  assign nextPtr = (winIdx == reqIdxT'(`TCM_NUM_REQ - 1)) ? '0 : winIdx + 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptrQ <= '0;
    end else if (contested) begin
      ptrQ <= nextPtr;
    end
  end

  // only one requester may own the bank port
  assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(bankGnt_o))
    else $error("bank %0d granted several requesters: %b", BankIdx, bankGnt_o);

  // the SRAM strobe and the grants must agree
  assert property (@(posedge clk_i) disable iff (!rst_ni) sramReq_o == (|bankGnt_o))
    else $error("bank %0d SRAM request out of step with grants", BankIdx);

endmodule

// File: logic/tcSram.sv
// ----------------------------------------------------------------------
// tcSram
// behavioral single-port SRAM bank with byte-enable writes
// read data leaves through a register chain of Latency stages
// the read row is held so idle cycles keep presenting it
// ----------------------------------------------------------------------

`timescale 1ns/1ns

`include "tcm_defines.svh"

module tcSram #(
  parameter int unsigned NumWords = `TCM_ROWS_PER_BANK,
  parameter int unsigned Latency  = `TCM_READ_LATENCY
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         req_i,
  input  logic         we_i,
  input  tcmPkg::rowT  addr_i,
  input  tcmPkg::dataT wdata_i,
  input  tcmPkg::beT   be_i,
  output tcmPkg::dataT rdata_o
);

  import tcmPkg::*;

  localparam int unsigned ByteW  = `TCM_BYTE_WIDTH;
  localparam int unsigned LaneNo = $bits(beT);

  // storage array
  dataT memQ [NumWords];
  // row of the last read, kept for idle and write cycles
  rowT  rAddrQ;
  // data seen at the array this cycle
  dataT rdataNow;

  // zeros at start so reads before any write are predictable
  initial begin
    for (int unsigned w = 0; w < NumWords; w++) begin
      memQ[w] = '0;
    end
  end

  // a read looks at the new row, otherwise the held one
  assign rdataNow = (req_i && !we_i) ? memQ[addr_i] : memQ[rAddrQ];

  // byte-masked write at the accepting edge
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int unsigned b = 0; b < LaneNo; b++) begin
        if (be_i[b]) begin
          memQ[addr_i][b*ByteW +: ByteW] <= wdata_i[b*ByteW +: ByteW];
        end
      end
    end
  end

  // remember the read row
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rAddrQ <= '0;
    end else if (req_i && !we_i) begin
      rAddrQ <= addr_i;
    end
  end

  if (Latency == 0) begin : genNoLat
    // data straight from the array
    assign rdata_o = rdataNow;
  end else begin : genLat
    // stage Latency-1 is loaded, stage 0 drives the output
    dataT pipeQ [Latency];

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        for (int unsigned s = 0; s < Latency; s++) begin
          pipeQ[s] <= '0;
        end
      end else begin
        // array is sampled before this edge's write lands
        pipeQ[Latency-1] <= rdataNow;
        for (int unsigned s = 0; s + 1 < Latency; s++) begin
          pipeQ[s] <= pipeQ[s+1];
        end
      end
    end

    assign rdata_o = pipeQ[0];
  end

  // a write with no lane enabled would be lost silently
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_i && we_i) |-> (be_i != '0))
    else $error("write to row %0d with all byte enables low", addr_i);

endmodule

// File: logic/tcmPkg.sv
// ----------------------------------------------------------------------
// tcm types
// vector types shared by the banks, arbiters and response router
// ----------------------------------------------------------------------

`include "tcm_defines.svh"

package tcmPkg;

  // widths derived from the configuration
  localparam int unsigned DataW = `TCM_DATA_WIDTH;
  localparam int unsigned BeW   = `TCM_DATA_WIDTH / `TCM_BYTE_WIDTH;
  localparam int unsigned RowW  = $clog2(`TCM_ROWS_PER_BANK);
  localparam int unsigned BankW = $clog2(`TCM_NUM_BANKS);
  localparam int unsigned ReqW  = ($clog2(`TCM_NUM_REQ) > 0) ? $clog2(`TCM_NUM_REQ) : 1;

  typedef logic [DataW-1:0]      dataT;
  typedef logic [BeW-1:0]        beT;
  typedef logic [RowW-1:0]       rowT;
  typedef logic [BankW-1:0]      bankIdxT;
  typedef logic [ReqW-1:0]       reqIdxT;
  // word address, row on top and bank select in the low bits
  typedef logic [RowW+BankW-1:0] addrT;

endpackage

// File: include/tcm_defines.svh
// ----------------------------------------------------------------------
// tightly coupled data memory configuration
// bank count, bank depth, word and lane widths, requesters, latency
// ----------------------------------------------------------------------

`ifndef TCM_DEFINES_SVH
`define TCM_DEFINES_SVH

// four banks, word addresses interleaved on the low bits
`define TCM_NUM_BANKS 4
// words held by each bank
`define TCM_ROWS_PER_BANK 256
// data word and byte lane widths
`define TCM_DATA_WIDTH 32
`define TCM_BYTE_WIDTH 8
// load/store unit and DMA engine
`define TCM_NUM_REQ 2
// cycles from an accepted read to its rvalid
`define TCM_READ_LATENCY 1

`endif
